// ==== all.f ====
+incdir+include
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ls_unit.sv
verilog/data_ram.sv
verilog/pipe_reg.sv
verilog/mem_stage_top.sv
verification/tb_mem_stage.sv

// ==== include/mem_consts.svh ====
// widths and memory depth shared by the packages and the memory-stage RTL
// include before any package or module that uses these macros
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data and address width of the RV64 datapath
`define XLEN 64

// destination register index width
`define REG_IDX_W 5

// log2 of the number of 64-bit data memory words
`define DMEM_AW 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the memory-stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_mem_stage -f all.f -Mdir "$build_dir" -o tb_mem_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_mem_stage_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$log_file"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== verification/tb_mem_stage.sv ====
// self-checking testbench for the memory-access stage
// drives one item per falling edge, checks store strobes and writeback against a model
module tb_mem_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN        = 3;
  localparam int IDLE_N       = 4;
  localparam int WORDS_N      = 32;
  localparam int ALU_N        = 20;
  localparam int STORE_N      = 15;
  localparam int LOAD_N       = 30;
  localparam int RAW_N        = 8;
  localparam int MIX_N        = 200;
  localparam int ITEMS_N = WORDS_N + ALU_N + STORE_N + LOAD_N + RAW_N + MIX_N;
  // one idle cycle at reset release, the idle test and a drain after each test
  localparam int IDLE_TOTAL  = 1 + IDLE_N + 5 * DRAIN;
  localparam int CYCLE_LIMIT = RESET_CYCLES + ITEMS_N + IDLE_TOTAL + 20;

  // what the stage should show for one driven cycle
  typedef struct packed {
    logic       valid;
    logic       wr_en;
    reg_idx_t   idx;
    xlen_t      wb_data;
    logic       is_store;
    xlen_t      waddr;
    byte_mask_t wmask;
    xlen_t      wdata;
  } stage_rec_t;

  logic       clk;
  logic       rst_n_i;
  logic       valid_i;
  logic       rd_wr_en_i;
  reg_idx_t   rd_idx_i;
  xlen_t      alu_res_i;
  ls_info_t   ls_info_i;
  xlen_t      rs2_store_i;
  logic       wb_valid_o;
  logic       rd_wr_en_o;
  reg_idx_t   rd_idx_o;
  xlen_t      rd_data_o;
  logic       mem_wen_o;
  xlen_t      mem_waddr_o;
  byte_mask_t mem_wmask_o;
  xlen_t      mem_wdata_o;

  logic [7:0] model_mem [xlen_t];
  stage_rec_t rec_q [$];
  int         pass_count = 0;
  int         fail_count = 0;
  int         test_start = 0;

  mem_stage_top mem_stage_top_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .rd_wr_en_i  (rd_wr_en_i),
    .rd_idx_i    (rd_idx_i),
    .alu_res_i   (alu_res_i),
    .ls_info_i   (ls_info_i),
    .rs2_store_i (rs2_store_i),
    .wb_valid_o  (wb_valid_o),
    .rd_wr_en_o  (rd_wr_en_o),
    .rd_idx_o    (rd_idx_o),
    .rd_data_o   (rd_data_o),
    .mem_wen_o   (mem_wen_o),
    .mem_waddr_o (mem_waddr_o),
    .mem_wmask_o (mem_wmask_o),
    .mem_wdata_o (mem_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic int size_bytes(input ls_info_t info);
    if (info.is_byte) begin
      return 1;
    end else if (info.is_half) begin
      return 2;
    end else if (info.is_word) begin
      return 4;
    end
    return 8;
  endfunction

  function automatic ls_info_t make_info(input logic ld, input logic st, input logic uns,
                                         input int nbytes);
    ls_info_t info;
    info = '0;
    info.is_load = ld;
    info.is_store = st;
    info.is_unsigned = uns;
    info.is_byte = (nbytes == 1);
    info.is_half = (nbytes == 2);
    info.is_word = (nbytes == 4);
    info.is_double = (nbytes == 8);
    return info;
  endfunction

  // little-endian bytes from the model memory, then sign or zero extension
  function automatic xlen_t expected_result(input ls_info_t info, input xlen_t addr);
    xlen_t raw;
    int    nbytes;
    logic  sign;
    raw = '0;
    nbytes = size_bytes(info);
    if (!info.is_load) begin
      return addr;
    end
    for (int i = 0; i < nbytes; i++) begin
      raw[8*i +: 8] = model_mem[addr + xlen_t'(i)];
    end
    sign = raw[8*nbytes-1] & !info.is_unsigned;
    for (int i = nbytes; i < 8; i++) begin
      raw[8*i +: 8] = {8{sign}};
    end
    return raw;
  endfunction

  task automatic model_store(input xlen_t addr, input xlen_t rs2, input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      model_mem[addr + xlen_t'(i)] = rs2[8*i +: 8];
    end
  endtask

  task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic issue(input ls_info_t info, input logic wr_en, input reg_idx_t idx,
                       input xlen_t alu, input xlen_t rs2);
    stage_rec_t rec;
    int         nbytes;
    nbytes = size_bytes(info);
    rec = '0;
    rec.valid = 1'b1;
    rec.wr_en = wr_en;
    rec.idx = idx;
    rec.wb_data = expected_result(info, alu);
    rec.is_store = info.is_store;
    if (info.is_store) begin
      rec.waddr = alu;
      for (int i = 0; i < nbytes; i++) begin
        rec.wmask[int'(alu[2:0]) + i] = 1'b1;
      end
      rec.wdata = rs2 << (8 * alu[2:0]);
      model_store(alu, rs2, nbytes);
    end
    @(negedge clk);
    valid_i = 1'b1;
    rd_wr_en_i = wr_en;
    rd_idx_i = idx;
    alu_res_i = alu;
    ls_info_i = info;
    rs2_store_i = rs2;
    rec_q.push_back(rec);
  endtask

  task automatic drive_idle();
    stage_rec_t rec;
    rec = '0;
    @(negedge clk);
    valid_i = 1'b0;
    // junk behind a low valid must not reach memory or writeback
    rd_wr_en_i = 1'b1;
    ls_info_i = make_info(1'b0, 1'b1, 1'b0, 8);
    alu_res_i = rand64();
    rs2_store_i = rand64();
    rec_q.push_back(rec);
  endtask

  task automatic end_test(input int num, input string name);
    repeat (DRAIN) drive_idle();
    $display("test %0d %s: %0d errors", num, name, fail_count - test_start);
    test_start = fail_count;
  endtask

  // mem strobes belong to the item driven one edge ago, writeback to two
  initial begin : compare_proc
    stage_rec_t cur;
    stage_rec_t prev;
    prev = '0;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk);
      #10;
      check_value("wb_valid_o", xlen_t'(wb_valid_o), xlen_t'(prev.valid));
      check_value("rd_wr_en_o", xlen_t'(rd_wr_en_o), xlen_t'(prev.valid & prev.wr_en));
      if (prev.valid) begin
        check_value("rd_idx_o", xlen_t'(rd_idx_o), xlen_t'(prev.idx));
        check_value("rd_data_o", rd_data_o, prev.wb_data);
      end
      cur = '0;
      if (rec_q.size() > 0) begin
        cur = rec_q.pop_front();
      end
      check_value("mem_wen_o", xlen_t'(mem_wen_o), xlen_t'(cur.valid & cur.is_store));
      if (cur.valid && cur.is_store) begin
        check_value("mem_waddr_o", mem_waddr_o, cur.waddr);
        check_value("mem_wmask_o", xlen_t'(mem_wmask_o), xlen_t'(cur.wmask));
        check_value("mem_wdata_o", mem_wdata_o, cur.wdata);
      end
      prev = cur;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main_proc
    xlen_t addr;
    int    nbytes;
    int    kind;
    reg_idx_t idx;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    rd_wr_en_i = 1'b0;
    rd_idx_i = '0;
    alu_res_i = '0;
    ls_info_i = '0;
    rs2_store_i = '0;
    void'($urandom(32'h598cc206));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    repeat (IDLE_N) drive_idle();
    end_test(1, "outputs idle after reset");

    for (int i = 0; i < ALU_N; i++) begin
      issue('0, 1'($urandom), reg_idx_t'($urandom), rand64(), rand64());
    end
    end_test(2, "alu pass-through");

    // full doublewords first so every later load reads written bytes
    for (int w = 0; w < WORDS_N; w++) begin
      issue(make_info(1'b0, 1'b1, 1'b0, 8), 1'b0, '0, xlen_t'(w * 8), rand64());
    end
    for (int s = 0; s < 4; s++) begin
      nbytes = 1 << s;
      for (int off = 0; off < 8; off += nbytes) begin
        addr = xlen_t'((8 + s) * 8 + off);
        issue(make_info(1'b0, 1'b1, 1'b0, nbytes), 1'b0, '0, addr, rand64());
      end
    end
    end_test(3, "stores at every size and offset");

    for (int s = 0; s < 4; s++) begin
      nbytes = 1 << s;
      for (int u = 0; u < 2; u++) begin
        for (int off = 0; off < 8; off += nbytes) begin
          addr = xlen_t'((16 + s) * 8 + off);
          issue(make_info(1'b1, 1'b0, 1'(u), nbytes), 1'b1, reg_idx_t'($urandom), addr,
                rand64());
        end
      end
    end
    // load right behind a store to the same bytes
    for (int s = 0; s < 4; s++) begin
      nbytes = 1 << s;
      addr = xlen_t'((24 + s) * 8 + 8 - nbytes);
      issue(make_info(1'b0, 1'b1, 1'b0, nbytes), 1'b0, '0, addr, rand64());
      issue(make_info(1'b1, 1'b0, 1'b0, nbytes), 1'b1, reg_idx_t'($urandom), addr, rand64());
    end
    end_test(4, "loads with extension and store-load pairs");

    for (int i = 0; i < MIX_N; i++) begin
      kind = $urandom_range(2, 0);
      nbytes = 1 << $urandom_range(3, 0);
      idx = reg_idx_t'($urandom);
      addr = xlen_t'($urandom_range(WORDS_N - 1, 0) * 8
                     + $urandom_range(8 / nbytes - 1, 0) * nbytes);
      if (kind == 0) begin
        issue('0, 1'($urandom), idx, rand64(), rand64());
      end else if (kind == 1) begin
        issue(make_info(1'b0, 1'b1, 1'b0, nbytes), 1'b0, idx, addr, rand64());
      end else begin
        issue(make_info(1'b1, 1'b0, 1'($urandom), nbytes), 1'b1, idx, addr, rand64());
      end
    end
    end_test(5, "random mix");

    @(posedge clk);
    #15;
    if (rec_q.size() != 0) begin
      $display("%0d expected items were never compared", rec_q.size());
      fail_count++;
    end
    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/data_ram.sv ====
// data memory of the memory stage with 64-bit words
// combinational read, byte-masked write at the rising clock edge
`include "mem_consts.svh"

module data_ram (
  input  logic                   clk,
  input  logic                   mem_ren_i,
  input  rv_isa_pkg::xlen_t      raddr_i,
  output rv_isa_pkg::xlen_t      rdata_o,
  input  logic                   mem_wen_i,
  input  rv_isa_pkg::xlen_t      waddr_i,
  input  rv_isa_pkg::byte_mask_t wmask_i,
  input  rv_isa_pkg::xlen_t      wdata_i
);

  import rv_isa_pkg::*;

  localparam int unsigned DEPTH = 1 << `DMEM_AW;

  xlen_t              mem [DEPTH];
  logic [`DMEM_AW-1:0] ridx;
  logic [`DMEM_AW-1:0] widx;

  // word index sits above the byte offset
  assign ridx = raddr_i[`DMEM_AW+2:3];
  assign widx = waddr_i[`DMEM_AW+2:3];

  assign rdata_o = mem_ren_i ? mem[ridx] : '0;

  always_ff @(posedge clk) begin
    if (mem_wen_i) begin
      for (int b = 0; b < `XLEN/8; b++) begin
        if (wmask_i[b]) begin
          mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // addresses beyond the array would alias onto low words
  rd_in_range: assert property (@(posedge clk)
    mem_ren_i |-> (raddr_i[`XLEN-1:`DMEM_AW+3] == '0))
    else $error("data_ram: read address %h out of range", raddr_i);

  wr_in_range: assert property (@(posedge clk)
    mem_wen_i |-> (waddr_i[`XLEN-1:`DMEM_AW+3] == '0))
    else $error("data_ram: write address %h out of range", waddr_i);

endmodule

// ==== verilog/ls_unit.sv ====
// combinational load/store unit of the memory stage
// builds store mask and data, aligns and extends load data, passes ALU results
`include "mem_consts.svh"

module ls_unit (
  input  logic                  valid_i,
  input  logic                  rd_wr_en_i,
  input  rv_isa_pkg::reg_idx_t  rd_idx_i,
  input  rv_isa_pkg::xlen_t     alu_res_i,
  input  rv_isa_pkg::ls_info_t  ls_info_i,
  input  rv_isa_pkg::xlen_t     rs2_store_i,
  input  rv_isa_pkg::xlen_t     mem_rdata_i,

  output logic                  rd_wr_en_o,
  output rv_isa_pkg::reg_idx_t  rd_idx_o,
  output rv_isa_pkg::xlen_t     rd_data_o,

  output logic                  mem_ren_o,
  output rv_isa_pkg::xlen_t     mem_raddr_o,
  output logic                  mem_wen_o,
  output rv_isa_pkg::xlen_t     mem_waddr_o,
  output rv_isa_pkg::byte_mask_t mem_wmask_o,
  output rv_isa_pkg::xlen_t     mem_wdata_o
);

  import rv_isa_pkg::*;

  logic       ls_load;
  logic       ls_store;
  logic [2:0] offset;
  logic [5:0] bit_shift;
  logic [3:0] size_bits;
  logic       misaligned;
  xlen_t      lane_data;
  xlen_t      load_data;

  // only a valid item may touch memory
  assign ls_load  = valid_i & ls_info_i.is_load;
  assign ls_store = valid_i & ls_info_i.is_store;

  assign offset    = alu_res_i[2:0];
  assign bit_shift = {offset, 3'b000};

  assign size_bits = {ls_info_i.is_double, ls_info_i.is_word,
                      ls_info_i.is_half, ls_info_i.is_byte};

  assign misaligned = (ls_info_i.is_half   & offset[0])
                    | (ls_info_i.is_word   & (|offset[1:0]))
                    | (ls_info_i.is_double & (|offset));

  // store mask and data move to the addressed lane
  assign mem_wen_o   = ls_store;
  assign mem_waddr_o = ls_store ? alu_res_i : '0;
  assign mem_wmask_o = ls_store ? (ls_size_mask(ls_info_i) << offset) : '0;
  assign mem_wdata_o = ls_store ? (rs2_store_i << bit_shift) : '0;

  // load side
  assign mem_ren_o   = ls_load;
  assign mem_raddr_o = ls_load ? alu_res_i : '0;

  // bring the addressed byte down to lane 0
  assign lane_data = mem_rdata_i >> bit_shift;

  always_comb begin
    load_data = lane_data;
    if (ls_info_i.is_byte) begin
      load_data = ls_info_i.is_unsigned ?
                  {{(`XLEN-8){1'b0}}, lane_data[7:0]} :
                  {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
    end else if (ls_info_i.is_half) begin
      load_data = ls_info_i.is_unsigned ?
                  {{(`XLEN-16){1'b0}}, lane_data[15:0]} :
                  {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
    end else if (ls_info_i.is_word) begin
      load_data = ls_info_i.is_unsigned ?
                  {{(`XLEN-32){1'b0}}, lane_data[31:0]} :
                  {{(`XLEN-32){lane_data[31]}}, lane_data[31:0]};
    end
  end

  assign rd_wr_en_o = valid_i & rd_wr_en_i;
  assign rd_idx_o   = rd_idx_i;
  assign rd_data_o  = ls_load ? load_data : alu_res_i;

  // decode sanity on every valid item
  always_comb begin
    if (valid_i) begin
      assert (!(ls_info_i.is_load && ls_info_i.is_store))
        else $error("ls_unit: load and store set together");
      if (ls_info_i.is_load || ls_info_i.is_store) begin
        assert ($onehot(size_bits))
          else $error("ls_unit: size bits %b not one-hot", size_bits);
        // misaligned accesses are not split, only reported
        assert (!misaligned)
          else $error("ls_unit: misaligned access at %h", alu_res_i);
      end
    end
  end

endmodule

// ==== verilog/mem_stage_top.sv ====
// memory-access stage with input register, load/store unit, data memory and
// writeback register, at a fixed latency of two cycles
module mem_stage_top (
  input  logic                   clk,
  input  logic                   rst_n_i,

  // one execute-stage result per cycle
  input  logic                   valid_i,
  input  logic                   rd_wr_en_i,
  input  rv_isa_pkg::reg_idx_t   rd_idx_i,
  input  rv_isa_pkg::xlen_t      alu_res_i,
  input  rv_isa_pkg::ls_info_t   ls_info_i,
  input  rv_isa_pkg::xlen_t      rs2_store_i,

  // writeback
  output logic                   wb_valid_o,
  output logic                   rd_wr_en_o,
  output rv_isa_pkg::reg_idx_t   rd_idx_o,
  output rv_isa_pkg::xlen_t      rd_data_o,

  // store being committed this cycle
  output logic                   mem_wen_o,
  output rv_isa_pkg::xlen_t      mem_waddr_o,
  output rv_isa_pkg::byte_mask_t mem_wmask_o,
  output rv_isa_pkg::xlen_t      mem_wdata_o
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  ex_mem_t ex_in;
  ex_mem_t ex_q;
  logic    ex_valid;
  mem_wb_t wb_in;
  mem_wb_t wb_q;
  logic    mem_ren;
  xlen_t   mem_raddr;
  xlen_t   mem_rdata;

  assign ex_in = '{rd_wr_en:  rd_wr_en_i,
                   rd_idx:    rd_idx_i,
                   alu_res:   alu_res_i,
                   ls_info:   ls_info_i,
                   rs2_store: rs2_store_i};

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .data_i  (ex_in),
    .valid_o (ex_valid),
    .data_o  (ex_q)
  );

  ls_unit ls_unit_inst (
    .valid_i     (ex_valid),
    .rd_wr_en_i  (ex_q.rd_wr_en),
    .rd_idx_i    (ex_q.rd_idx),
    .alu_res_i   (ex_q.alu_res),
    .ls_info_i   (ex_q.ls_info),
    .rs2_store_i (ex_q.rs2_store),
    .mem_rdata_i (mem_rdata),
    .rd_wr_en_o  (wb_in.rd_wr_en),
    .rd_idx_o    (wb_in.rd_idx),
    .rd_data_o   (wb_in.rd_data),
    .mem_ren_o   (mem_ren),
    .mem_raddr_o (mem_raddr),
    .mem_wen_o   (mem_wen_o),
    .mem_waddr_o (mem_waddr_o),
    .mem_wmask_o (mem_wmask_o),
    .mem_wdata_o (mem_wdata_o)
  );

  data_ram data_ram_inst (
    .clk       (clk),
    .mem_ren_i (mem_ren),
    .raddr_i   (mem_raddr),
    .rdata_o   (mem_rdata),
    .mem_wen_i (mem_wen_o),
    .waddr_i   (mem_waddr_o),
    .wmask_i   (mem_wmask_o),
    .wdata_i   (mem_wdata_o)
  );

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (ex_valid),
    .data_i  (wb_in),
    .valid_o (wb_valid_o),
    .data_o  (wb_q)
  );

  // the held payload may be stale, only a valid item writes back
  assign rd_wr_en_o = wb_valid_o & wb_q.rd_wr_en;
  assign rd_idx_o   = wb_q.rd_idx;
  assign rd_data_o  = wb_q.rd_data;

endmodule

// ==== verilog/pipe_pkg.sv ====
// payload structs held by the two stage registers around the memory stage
// the stage top packs its loose ports into these
`include "mem_consts.svh"

package pipe_pkg;

  import rv_isa_pkg::*;

  // one execute-to-memory item per cycle
  typedef struct packed {
    logic     rd_wr_en;
    reg_idx_t rd_idx;
    // address for loads and stores, result otherwise
    xlen_t    alu_res;
    ls_info_t ls_info;
    xlen_t    rs2_store;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    logic     rd_wr_en;
    reg_idx_t rd_idx;
    xlen_t    rd_data;
  } mem_wb_t;

endpackage

// ==== verilog/pipe_reg.sv ====
// pipeline stage register for any payload type
// valid is cleared by reset, payload only loads with a valid item
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // holds the last valid item while the stage is empty
  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

  // nothing leaves the register right after reset
  empty_after_rst: assert property (@(posedge clk) !rst_n_i |=> !valid_o)
    else $error("pipe_reg: valid_o set in the cycle after reset");

endmodule

// ==== verilog/rv_isa_pkg.sv ====
// ISA-level types for the memory-access stage: data words, register indices
// and the load/store control word from decode
`include "mem_consts.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // one enable bit per byte lane of a data word
  typedef logic [`XLEN/8-1:0] byte_mask_t;

  // load/store control word with load in bit 0 and double in bit 6
  typedef struct packed {
    logic is_double;
    logic is_word;
    logic is_half;
    logic is_byte;
    logic is_unsigned;
    logic is_store;
    logic is_load;
  } ls_info_t;

  // unshifted byte enable for the access size
  function automatic byte_mask_t ls_size_mask(input ls_info_t info);
    byte_mask_t mask;
    mask = '0;
    if (info.is_byte) begin
      mask = byte_mask_t'(8'h01);
    end else if (info.is_half) begin
      mask = byte_mask_t'(8'h03);
    end else if (info.is_word) begin
      mask = byte_mask_t'(8'h0f);
    end else if (info.is_double) begin
      mask = '1;
    end
    return mask;
  endfunction

endpackage
